// ==== design/piece_action_settings.svh ====
// ================================================
// piece action settings: playfield and piece sizes
// ================================================
`ifndef PIECE_ACTION_SETTINGS_SVH
`define PIECE_ACTION_SETTINGS_SVH

// playfield height, row 0 at the top
`define PA_ROWS 20

// playfield width
`define PA_COLS 10

`define PA_CELLS 4

`endif

// ==== design/piece_action_pkg.sv ====
// ================================================
// piece action types: piece, orientation, indices
// ================================================
`include "piece_action_settings.svh"

package piece_action_pkg;

    typedef logic [4:0] row_t;

    // wraps modulo 32 on moves
    typedef logic [4:0] col_t;

    typedef logic signed [2:0] offset_t;

    typedef enum logic [2:0] {
        I,
        O,
        T,
        J,
        L,
        S,
        Z
    } piece_t;

    // clockwise order
    typedef enum logic [1:0] {
        ORIENT_0,
        ORIENT_R,
        ORIENT_2,
        ORIENT_L
    } orientation_t;

    typedef logic [`PA_COLS-1:0] field_row_t;

endpackage

// ==== design/piece_shape_rom.sv ====
// ================================================
// piece shape ROM: cell offsets per type and turn
// ================================================
`timescale 1ns/1ns
`include "piece_action_settings.svh"

module piece_shape_rom (
    input  piece_action_pkg::piece_t       piece,
    input  piece_action_pkg::orientation_t orientation,
    output piece_action_pkg::offset_t      row_offsets [`PA_CELLS],
    output piece_action_pkg::offset_t      col_offsets [`PA_CELLS]
);
    import piece_action_pkg::*;

    // four row offsets then four column offsets
    offset_t [2*`PA_CELLS-1:0] cells;

    always_comb begin
        case ({piece, orientation})
            {I, ORIENT_0}: cells = '{0, 0, 0, 0, -2, -1, 0, 1};
            {I, ORIENT_R}: cells = '{-2, -1, 0, 1, 0, 0, 0, 0};
            {I, ORIENT_2}: cells = '{0, 0, 0, 0, -2, -1, 0, 1};
            {I, ORIENT_L}: cells = '{-2, -1, 0, 1, -1, -1, -1, -1};
            {O, ORIENT_0}: cells = '{-1, -1, 0, 0, -1, 0, -1, 0};
            {O, ORIENT_R}: cells = '{-1, -1, 0, 0, -1, 0, -1, 0};
            {O, ORIENT_2}: cells = '{-1, -1, 0, 0, -1, 0, -1, 0};
            {O, ORIENT_L}: cells = '{-1, -1, 0, 0, -1, 0, -1, 0};
            // T points up in spawn orientation
            {T, ORIENT_0}: cells = '{0, 0, 0, -1, -1, 0, 1, 0};
            {T, ORIENT_R}: cells = '{-1, 0, 1, 0, 0, 0, 0, 1};
            {T, ORIENT_2}: cells = '{0, 0, 0, 1, -1, 0, 1, 0};
            {T, ORIENT_L}: cells = '{-1, 0, 1, 0, 0, 0, 0, -1};
            {J, ORIENT_0}: cells = '{-1, 0, 0, 0, -1, -1, 0, 1};
            {J, ORIENT_R}: cells = '{-1, -1, 0, 1, 0, 1, 0, 0};
            {J, ORIENT_2}: cells = '{0, 0, 0, 1, -1, 0, 1, 1};
            {J, ORIENT_L}: cells = '{-1, 0, 1, 1, 0, 0, 0, -1};
            {L, ORIENT_0}: cells = '{-1, 0, 0, 0, 1, -1, 0, 1};
            {L, ORIENT_R}: cells = '{-1, 0, 1, 1, 0, 0, 0, 1};
            {L, ORIENT_2}: cells = '{0, 0, 0, 1, -1, 0, 1, -1};
            {L, ORIENT_L}: cells = '{-1, -1, 0, 1, -1, 0, 0, 0};
            {S, ORIENT_0}: cells = '{-1, -1, 0, 0, 0, 1, -1, 0};
            {S, ORIENT_R}: cells = '{-1, 0, 0, 1, 0, 0, 1, 1};
            {S, ORIENT_2}: cells = '{0, 0, 1, 1, 0, 1, -1, 0};
            {S, ORIENT_L}: cells = '{-1, 0, 0, 1, -1, -1, 0, 0};
            {Z, ORIENT_0}: cells = '{-1, -1, 0, 0, -1, 0, 0, 1};
            {Z, ORIENT_R}: cells = '{-1, 0, 0, 1, 1, 0, 1, 0};
            {Z, ORIENT_2}: cells = '{0, 0, 1, 1, -1, 0, 0, 1};
            {Z, ORIENT_L}: cells = '{-1, 0, 0, 1, 0, -1, 0, -1};
            // unused piece code, single cell at the origin
            default:       cells = '{0, 0, 0, 0, 0, 0, 0, 0};
        endcase
    end

    always_comb begin
        for (int i = 0; i < `PA_CELLS; i++) begin
            row_offsets[i] = cells[2*`PA_CELLS-1-i];
            col_offsets[i] = cells[`PA_CELLS-1-i];
        end
    end

endmodule

// ==== design/fit_checker.sv ====
// ================================================
// fit checker: piece cells vs locked playfield
// ================================================
`timescale 1ns/1ns
`include "piece_action_settings.svh"

module fit_checker (
    input  piece_action_pkg::row_t       cand_row,
    input  piece_action_pkg::col_t       origin_col,
    input  piece_action_pkg::offset_t    row_offsets [`PA_CELLS],
    input  piece_action_pkg::offset_t    col_offsets [`PA_CELLS],
    input  piece_action_pkg::field_row_t playfield [`PA_ROWS],
    output logic                         fits
);
    import piece_action_pkg::*;

    logic signed [6:0]    cell_r [`PA_CELLS];
    logic signed [6:0]    cell_c [`PA_CELLS];
    logic [`PA_CELLS-1:0] cell_ok;

    always_comb begin
        for (int i = 0; i < `PA_CELLS; i++) begin
            cell_r[i] = $signed({2'b00, cand_row}) + row_offsets[i];
            cell_c[i] = $signed({2'b00, origin_col}) + col_offsets[i];
            // bounds first, the index is only meaningful inside the field
            cell_ok[i] = (cell_r[i] >= 0) && (cell_r[i] < `PA_ROWS) &&
                         (cell_c[i] >= 0) && (cell_c[i] < `PA_COLS) &&
                         !playfield[cell_r[i][4:0]][cell_c[i][3:0]];
        end
    end

    assign fits = &cell_ok;

endmodule

// ==== design/row_scan_counter.sv ====
// ================================================
// row scan counter: candidate row for hard drop
// ================================================
`timescale 1ns/1ns
`include "piece_action_settings.svh"

module row_scan_counter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load,
    input  logic                   step,
    input  piece_action_pkg::row_t origin_row,
    output piece_action_pkg::row_t cand_row,
    output logic                   at_limit
);
    import piece_action_pkg::*;

    // first candidate is one below the origin
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cand_row <= '0;
        end else if (load) begin
            cand_row <= origin_row + 5'd1;
        end else if (step) begin
            cand_row <= cand_row + 5'd1;
        end
    end

    // past the bottom row
    assign at_limit = (cand_row >= row_t'(`PA_ROWS));

endmodule

// ==== design/drop_sequencer.sv ====
// ================================================
// drop sequencer: request, row scan and result FSM
// ================================================
`timescale 1ns/1ns

module drop_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  logic req_valid,
    output logic req_ready,
    input  logic fits,
    input  logic at_limit,
    output logic load,
    output logic step,
    output logic capture,
    output logic res_valid,
    input  logic res_ready
);

    typedef enum logic [1:0] {
        s_idle,
        s_scan,
        s_hold
    } state_t;

    state_t state;
    state_t state_next;
    logic   scan_done;

    assign req_ready = (state == s_idle);
    assign res_valid = (state == s_hold);
    assign load      = req_valid && req_ready;

    // scan stops at the first blocked row or below the field
    assign scan_done = (state == s_scan) && (at_limit || !fits);
    assign step      = (state == s_scan) && !scan_done;
    assign capture   = scan_done;

    always_comb begin
        state_next = state;
        case (state)
            s_idle: begin
                if (load) begin
                    state_next = s_scan;
                end
            end
            s_scan: begin
                if (scan_done) begin
                    state_next = s_hold;
                end
            end
            s_hold: begin
                if (res_ready) begin
                    state_next = s_idle;
                end
            end
            default: state_next = s_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== design/move_candidates.sv ====
// ================================================
// move candidates: rotate, shift and soft-drop targets
// ================================================
`timescale 1ns/1ns

module move_candidates (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           accept,
    input  piece_action_pkg::row_t         origin_row,
    input  piece_action_pkg::col_t         origin_col,
    input  piece_action_pkg::orientation_t orientation,
    output piece_action_pkg::orientation_t rot_r_orientation,
    output piece_action_pkg::orientation_t rot_l_orientation,
    output piece_action_pkg::col_t         move_r_col,
    output piece_action_pkg::col_t         move_l_col,
    output piece_action_pkg::row_t         soft_drop_row
);
    import piece_action_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rot_r_orientation <= ORIENT_0;
            rot_l_orientation <= ORIENT_0;
            move_r_col        <= '0;
            move_l_col        <= '0;
            soft_drop_row     <= '0;
        end else if (accept) begin
            // enum order is clockwise, so +1 turns right
            rot_r_orientation <= orientation_t'(orientation + 2'd1);
            rot_l_orientation <= orientation_t'(orientation - 2'd1);
            // column wraps modulo 32
            move_r_col        <= origin_col + 5'd1;
            move_l_col        <= origin_col - 5'd1;
            soft_drop_row     <= origin_row + 5'd1;
        end
    end

endmodule

// ==== design/drop_result.sv ====
// ================================================
// drop result: landing row and ghost cells
// ================================================
`timescale 1ns/1ns
`include "piece_action_settings.svh"

module drop_result (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      capture,
    input  piece_action_pkg::row_t    cand_row,
    input  piece_action_pkg::col_t    origin_col,
    input  piece_action_pkg::offset_t row_offsets [`PA_CELLS],
    input  piece_action_pkg::offset_t col_offsets [`PA_CELLS],
    output piece_action_pkg::row_t    landing_row,
    output piece_action_pkg::row_t    ghost_rows [`PA_CELLS],
    output piece_action_pkg::col_t    ghost_cols [`PA_CELLS]
);
    import piece_action_pkg::*;

    row_t land_next;

    // candidate row is the first that failed, so land one above it
    assign land_next = cand_row - 5'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            landing_row <= '0;
            ghost_rows  <= '{default: '0};
            ghost_cols  <= '{default: '0};
        end else if (capture) begin
            landing_row <= land_next;
            for (int i = 0; i < `PA_CELLS; i++) begin
                ghost_rows[i] <= land_next + row_t'(row_offsets[i]);
                ghost_cols[i] <= origin_col + col_t'(col_offsets[i]);
            end
        end
    end

endmodule

// ==== design/piece_action_unit.sv ====
// ================================================
// piece action unit: action targets and hard drop
// ================================================
`timescale 1ns/1ns
`include "piece_action_settings.svh"

module piece_action_unit (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           req_valid,
    output logic                           req_ready,
    input  piece_action_pkg::piece_t       piece,
    input  piece_action_pkg::orientation_t orientation,
    input  piece_action_pkg::row_t         origin_row,
    input  piece_action_pkg::col_t         origin_col,
    input  piece_action_pkg::field_row_t   playfield [`PA_ROWS],
    output piece_action_pkg::orientation_t rot_r_orientation,
    output piece_action_pkg::orientation_t rot_l_orientation,
    output piece_action_pkg::col_t         move_r_col,
    output piece_action_pkg::col_t         move_l_col,
    output piece_action_pkg::row_t         soft_drop_row,
    output piece_action_pkg::row_t         landing_row,
    output piece_action_pkg::row_t         ghost_rows [`PA_CELLS],
    output piece_action_pkg::col_t         ghost_cols [`PA_CELLS],
    output logic                           res_valid,
    input  logic                           res_ready
);
    import piece_action_pkg::*;

    // request held for the scan
    piece_t       cur_piece;
    orientation_t cur_orient;
    col_t         cur_col;

    offset_t      row_offsets [`PA_CELLS];
    offset_t      col_offsets [`PA_CELLS];
    row_t         cand_row;
    logic         fits;
    logic         at_limit;
    logic         load;
    logic         step;
    logic         capture;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_piece  <= I;
            cur_orient <= ORIENT_0;
            cur_col    <= '0;
        end else if (load) begin
            cur_piece  <= piece;
            cur_orient <= orientation;
            cur_col    <= origin_col;
        end
    end

    piece_shape_rom u_shape_rom (
        .piece       (cur_piece),
        .orientation (cur_orient),
        .row_offsets (row_offsets),
        .col_offsets (col_offsets)
    );

    fit_checker u_fit_checker (
        .cand_row    (cand_row),
        .origin_col  (cur_col),
        .row_offsets (row_offsets),
        .col_offsets (col_offsets),
        .playfield   (playfield),
        .fits        (fits)
    );

    row_scan_counter u_row_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .step       (step),
        .origin_row (origin_row),
        .cand_row   (cand_row),
        .at_limit   (at_limit)
    );

    drop_sequencer u_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .fits      (fits),
        .at_limit  (at_limit),
        .load      (load),
        .step      (step),
        .capture   (capture),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

    // load doubles as the acceptance pulse
    move_candidates u_moves (
        .clk               (clk),
        .rst_n             (rst_n),
        .accept            (load),
        .origin_row        (origin_row),
        .origin_col        (origin_col),
        .orientation       (orientation),
        .rot_r_orientation (rot_r_orientation),
        .rot_l_orientation (rot_l_orientation),
        .move_r_col        (move_r_col),
        .move_l_col        (move_l_col),
        .soft_drop_row     (soft_drop_row)
    );

    drop_result u_drop_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .capture     (capture),
        .cand_row    (cand_row),
        .origin_col  (cur_col),
        .row_offsets (row_offsets),
        .col_offsets (col_offsets),
        .landing_row (landing_row),
        .ghost_rows  (ghost_rows),
        .ghost_cols  (ghost_cols)
    );

endmodule

// ==== verif/piece_action_checker.sv ====
// ================================================
// piece action checker: compares every result
// ================================================
`timescale 1ns/1ns
`include "piece_action_settings.svh"

module piece_action_checker (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           req_valid,
    input  logic                           req_ready,
    input  piece_action_pkg::orientation_t orientation,
    input  piece_action_pkg::row_t         origin_row,
    input  piece_action_pkg::col_t         origin_col,
    input  piece_action_pkg::row_t         exp_landing,
    input  piece_action_pkg::row_t         exp_ghost_rows [`PA_CELLS],
    input  piece_action_pkg::col_t         exp_ghost_cols [`PA_CELLS],
    input  piece_action_pkg::orientation_t rot_r_orientation,
    input  piece_action_pkg::orientation_t rot_l_orientation,
    input  piece_action_pkg::col_t         move_r_col,
    input  piece_action_pkg::col_t         move_l_col,
    input  piece_action_pkg::row_t         soft_drop_row,
    input  piece_action_pkg::row_t         landing_row,
    input  piece_action_pkg::row_t         ghost_rows [`PA_CELLS],
    input  piece_action_pkg::col_t         ghost_cols [`PA_CELLS],
    input  logic                           res_valid,
    input  logic                           res_ready,
    output int                             error_count,
    output int                             result_count
);
    import piece_action_pkg::*;

    localparam int RES_W = 24 + 10 * `PA_CELLS;

    int               errors = 0;
    int               results = 0;
    logic             in_reset;
    logic             stalled;
    logic [RES_W-1:0] result_now;
    logic [RES_W-1:0] held_result;
    orientation_t     req_orient;
    row_t             req_row;
    col_t             req_col;
    row_t             req_landing;
    row_t             req_ghost_rows [`PA_CELLS];
    col_t             req_ghost_cols [`PA_CELLS];

    assign error_count  = errors;
    assign result_count = results;

    // clockwise order is 0, R, 2, L
    function automatic orientation_t turn_right(input orientation_t o);
        case (o)
            ORIENT_0: return ORIENT_R;
            ORIENT_R: return ORIENT_2;
            ORIENT_2: return ORIENT_L;
            default:  return ORIENT_0;
        endcase
    endfunction

    task automatic compare_value(input string name, input int got, input int expected);
        if (got != expected) begin
            errors++;
            $display("error at %0t ns: %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    // all result outputs in one word for the stall check
    always_comb begin
        result_now = {rot_r_orientation, rot_l_orientation, move_r_col, move_l_col,
                      soft_drop_row, landing_row, {(10 * `PA_CELLS){1'b0}}};
        for (int i = 0; i < `PA_CELLS; i++) begin
            result_now[10*i +: 10] = {ghost_rows[i], ghost_cols[i]};
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            in_reset = 1'b1;
            stalled  = 1'b0;
        end else begin
            if (in_reset) begin
                compare_value("res_valid", res_valid, 0);
                compare_value("req_ready", req_ready, 1);
            end
            in_reset = 1'b0;
            if (res_valid) begin
                compare_value("req_ready", req_ready, 0);
            end
            if (stalled) begin
                compare_value("res_valid", res_valid, 1);
                if (result_now !== held_result) begin
                    errors++;
                    $display("error at %0t ns: result outputs got %h expected %h",
                             $time, result_now, held_result);
                end
            end
            stalled     = res_valid && !res_ready;
            held_result = result_now;
            if (req_valid && req_ready) begin
                req_orient     = orientation;
                req_row        = origin_row;
                req_col        = origin_col;
                req_landing    = exp_landing;
                req_ghost_rows = exp_ghost_rows;
                req_ghost_cols = exp_ghost_cols;
            end
            if (res_valid && res_ready) begin
                results++;
                compare_value("rot_r_orientation", rot_r_orientation, turn_right(req_orient));
                // three right turns make one left turn
                compare_value("rot_l_orientation", rot_l_orientation,
                              turn_right(turn_right(turn_right(req_orient))));
                compare_value("move_r_col", move_r_col, (int'(req_col) + 1) % 32);
                compare_value("move_l_col", move_l_col, (int'(req_col) + 31) % 32);
                compare_value("soft_drop_row", soft_drop_row, (int'(req_row) + 1) % 32);
                compare_value("landing_row", landing_row, req_landing);
                for (int i = 0; i < `PA_CELLS; i++) begin
                    compare_value($sformatf("ghost_rows[%0d]", i), ghost_rows[i],
                                  req_ghost_rows[i]);
                    compare_value($sformatf("ghost_cols[%0d]", i), ghost_cols[i],
                                  req_ghost_cols[i]);
                end
            end
        end
    end

endmodule

// ==== verif/piece_action_tb.sv ====
// ================================================
// piece action testbench: vectors from a data file
// ================================================
`timescale 1ns/1ns
`include "piece_action_settings.svh"

module piece_action_tb;
    import piece_action_pkg::*;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         req_valid;
    logic         req_ready;
    piece_t       piece;
    orientation_t orientation;
    row_t         origin_row;
    col_t         origin_col;
    field_row_t   playfield [`PA_ROWS];
    orientation_t rot_r_orientation;
    orientation_t rot_l_orientation;
    col_t         move_r_col;
    col_t         move_l_col;
    row_t         soft_drop_row;
    row_t         landing_row;
    row_t         ghost_rows [`PA_CELLS];
    col_t         ghost_cols [`PA_CELLS];
    logic         res_valid;
    logic         res_ready;
    row_t         exp_landing;
    row_t         exp_ghost_rows [`PA_CELLS];
    col_t         exp_ghost_cols [`PA_CELLS];
    int           error_count;
    int           result_count;
    string        vectors [$];
    int           setup_errors = 0;
    int           cycle_limit = 0;
    int           cycles = 0;
    int           seed = 32'h42b4_ea49;

    always #4 clk = ~clk;

    piece_action_unit uut (.*);

    piece_action_checker u_checker (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic load_vectors();
        int    fd;
        string line;
        fd = $fopen("verif/piece_action_stimulus.txt", "r");
        if (fd == 0) begin
            setup_errors++;
            $display("could not open the stimulus file");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    vectors.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_vector(input string line);
        int                     p;
        int                     o;
        int                     r;
        int                     c;
        int                     land;
        int                     gr [4];
        int                     gc [4];
        int                     n;
        logic [12*`PA_ROWS-1:0] field_word;
        field_word = '0;
        n = $sscanf(line, "%d %d %d %d %h %d %d %d %d %d %d %d %d %d",
                    p, o, r, c, field_word, land,
                    gr[0], gr[1], gr[2], gr[3], gc[0], gc[1], gc[2], gc[3]);
        if (n != 14) begin
            setup_errors++;
            $display("could not parse stimulus line: %s", line);
        end else begin
            @(negedge clk);
            piece       = piece_t'(p);
            orientation = orientation_t'(o);
            origin_row  = row_t'(r);
            origin_col  = col_t'(c);
            exp_landing = row_t'(land);
            // row 0 is in the leftmost hex digits
            for (int i = 0; i < `PA_ROWS; i++) begin
                playfield[i] = field_word[12*(`PA_ROWS-1-i) +: `PA_COLS];
            end
            for (int i = 0; i < `PA_CELLS; i++) begin
                exp_ghost_rows[i] = row_t'(gr[i]);
                exp_ghost_cols[i] = col_t'(gc[i]);
            end
            req_valid = 1'b1;
            while (!req_ready) begin
                @(negedge clk);
            end
            @(negedge clk);
            req_valid = 1'b0;
            do begin
                @(negedge clk);
                res_ready = ($random(seed) & 1) == 1;
            end while (!(res_valid && res_ready));
            @(negedge clk);
            res_ready = 1'b0;
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        res_ready      = 1'b0;
        piece          = I;
        orientation    = ORIENT_0;
        origin_row     = '0;
        origin_col     = '0;
        exp_landing    = '0;
        playfield      = '{default: '0};
        exp_ghost_rows = '{default: '0};
        exp_ghost_cols = '{default: '0};
        load_vectors();
        cycle_limit = vectors.size() * (`PA_ROWS + 10) + 16;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (vectors[i]) begin
            run_vector(vectors[i]);
        end
        repeat (2) @(negedge clk);
        if (result_count != vectors.size()) begin
            setup_errors++;
            $display("%0d vectors were sent but %0d results came back",
                     vectors.size(), result_count);
        end
        $display("%0d results checked, %0d value errors, %0d other errors",
                 result_count, error_count, setup_errors);
        if (error_count == 0 && setup_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== verif/piece_action_stimulus.txt ====
# piece(I O T J L S Z = 0..6) orient(0 R 2 L = 0..3) origin_row origin_col field landing
# ghost_row0..3 ghost_col0..3; field hex, 3 digits per row, row 0 first, empty top rows left out
0 0 2 4 0 19 19 19 19 19 2 3 4 5
0 1 2 4 0 18 16 17 18 19 4 4 4 4
0 2 2 4 0 19 19 19 19 19 2 3 4 5
0 3 2 4 0 18 16 17 18 19 3 3 3 3
1 0 1 9 0 19 18 18 19 19 8 9 8 9
1 1 1 9 0 19 18 18 19 19 8 9 8 9
1 2 1 9 0 19 18 18 19 19 8 9 8 9
1 3 1 9 0 19 18 18 19 19 8 9 8 9
2 0 1 7 0 19 19 19 19 18 6 7 8 7
2 1 1 7 0 18 17 18 19 18 7 7 7 8
2 2 1 7 0 18 18 18 18 19 6 7 8 7
2 3 1 7 0 18 17 18 19 18 7 7 7 6
3 0 0 4 0 19 18 19 19 19 3 3 4 5
3 1 0 4 0 18 17 17 18 19 4 5 4 4
3 2 0 4 0 18 18 18 18 19 3 4 5 5
3 3 0 4 0 18 17 18 19 19 4 4 4 3
4 0 0 4 0 19 18 19 19 19 5 3 4 5
4 1 0 4 0 18 17 18 19 19 4 4 4 5
4 2 0 4 0 18 18 18 18 19 3 4 5 3
4 3 0 4 0 18 17 17 18 19 3 4 4 4
5 0 2 4 0 19 18 18 19 19 4 5 3 4
5 1 2 4 0 18 17 18 18 19 4 4 5 5
5 2 2 4 0 18 18 18 19 19 4 5 3 4
5 3 2 4 0 18 17 18 18 19 3 3 4 4
6 0 2 4 0 19 18 18 19 19 3 4 4 5
6 1 2 4 0 18 17 18 18 19 5 4 5 4
6 2 2 4 0 18 18 18 19 19 3 4 4 5
6 3 2 4 0 18 17 18 18 19 4 3 4 3
1 0 1 4 3ff 18 17 17 18 18 3 4 3 4
0 0 2 4 200000004000000 16 16 16 16 16 2 3 4 5
3 0 1 4 020000000000000000000000000000 9 8 9 9 9 3 3 4 5
4 1 10 2 3ff000000000000000000000000000000008000000000 14 13 14 15 15 2 2 2 3
5 0 3 4 008000000000000000000000000000000000000000000000 3 2 2 3 3 4 5 3 4
6 1 1 6 080000040000000000000000 11 10 11 11 12 7 6 7 6
0 1 2 0 0013fd0013ff3ff 13 11 12 13 14 0 0 0 0
2 2 1 8 2802ff 17 17 17 17 18 7 8 9 8
0 1 2 31 0 2 0 1 2 3 31 31 31 31
0 0 5 0 0 5 5 5 5 5 30 31 0 1
1 0 19 4 0 19 18 18 19 19 3 4 3 4
4 0 1 5 040000000000000000000000000000000 8 7 8 8 8 6 4 5 6

// ==== all.f ====
+incdir+design
design/piece_action_pkg.sv
design/piece_shape_rom.sv
design/fit_checker.sv
design/row_scan_counter.sv
design/drop_sequencer.sv
design/move_candidates.sv
design/drop_result.sv
design/piece_action_unit.sv
verif/piece_action_checker.sv
verif/piece_action_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the piece action testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f \
    --top-module piece_action_tb -o sim_piece_action

./obj_dir/sim_piece_action | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
